// ==== hdl/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path and address width.
`define XLEN 32

`define REG_ADDR_W 5
`define REG_COUNT 32

// First fetch address after reset.
`define RESET_PC 32'h0000_0000

`endif

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // Major opcodes in instr[6:0].
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JUMP
    } branch_e;

endpackage

`default_nettype wire

// ==== hdl/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

    typedef enum logic [1:0] {STAGE_RUN, STAGE_PAUSE, STAGE_FLUSH} stage_ctrl_e;

    // Where an execute operand comes from.
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef enum logic [1:0] {A_RS1, A_PC} a_sel_e;

    typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} b_sel_e;

endpackage

`default_nettype wire

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module rv_decoder (
    input  wire [`XLEN-1:0]         instr,
    output logic [`REG_ADDR_W-1:0]  rd,
    output logic [`REG_ADDR_W-1:0]  rs1_addr,
    output logic [`REG_ADDR_W-1:0]  rs2_addr,
    output logic [`XLEN-1:0]        imm,
    output rv_isa_pkg::alu_op_e     alu_op,
    output rv_pipe_pkg::a_sel_e     a_sel,
    output rv_pipe_pkg::b_sel_e     b_sel,
    output rv_isa_pkg::branch_e     branch,
    output logic                    reg_we,
    output logic                    mem_to_reg,
    output logic                    mem_we
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    opcode_e            opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_s;
    logic [`XLEN-1:0]   imm_b;
    logic [`XLEN-1:0]   imm_u;
    logic [`XLEN-1:0]   imm_j;

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        alu_op     = ALU_ADD;
        a_sel      = A_RS1;
        b_sel      = B_RS2;
        branch     = BR_NONE;
        reg_we     = 1'b0;
        mem_to_reg = 1'b0;
        mem_we     = 1'b0;
        imm        = imm_i;
        case (opcode)
            OPC_OP: begin
                reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = ALU_ADD;
                    {7'h20, 3'b000}: alu_op = ALU_SUB;
                    {7'h00, 3'b001}: alu_op = ALU_SLL;
                    {7'h00, 3'b010}: alu_op = ALU_SLT;
                    {7'h00, 3'b100}: alu_op = ALU_XOR;
                    {7'h00, 3'b101}: alu_op = ALU_SRL;
                    {7'h20, 3'b101}: alu_op = ALU_SRA;
                    {7'h00, 3'b110}: alu_op = ALU_OR;
                    {7'h00, 3'b111}: alu_op = ALU_AND;
                    default:         reg_we = 1'b0;   // SLTU and the rest fall through as no-ops.
                endcase
            end
            OPC_OP_IMM: begin
                reg_we = 1'b1;
                b_sel  = B_IMM;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: reg_we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                reg_we = 1'b1;
                b_sel  = B_IMM;
                alu_op = ALU_PASS_B;
                imm    = imm_u;
            end
            OPC_LOAD: begin
                reg_we     = (funct3 == 3'b010);      // Word loads only.
                mem_to_reg = (funct3 == 3'b010);
                b_sel      = B_IMM;
            end
            OPC_STORE: begin
                mem_we = (funct3 == 3'b010);
                b_sel  = B_IMM;
                imm    = imm_s;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  branch = BR_EQ;
                    3'b001:  branch = BR_NE;
                    3'b100:  branch = BR_LT;
                    3'b101:  branch = BR_GE;
                    default: branch = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                reg_we = 1'b1;
                a_sel  = A_PC;                        // Link value is pc + 4.
                b_sel  = B_FOUR;
                branch = BR_JUMP;
                imm    = imm_j;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module rv_regfile (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire [`REG_ADDR_W-1:0]   rs1_addr,
    input  wire [`REG_ADDR_W-1:0]   rs2_addr,
    output logic [`XLEN-1:0]        rs1_data,
    output logic [`XLEN-1:0]        rs2_data,
    input  wire [`REG_ADDR_W-1:0]   wr_addr,
    input  wire [`XLEN-1:0]         wr_data,
    input  wire                     wr_en
);
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];   // x0 has no storage.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Writeback in the same cycle is seen by decode.
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== hdl/rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module rv_execute (
    input  wire [`XLEN-1:0]         pc,
    input  wire [`XLEN-1:0]         imm,
    input  wire [`XLEN-1:0]         rs1_data,
    input  wire [`XLEN-1:0]         rs2_data,
    input  wire rv_isa_pkg::alu_op_e    alu_op,
    input  wire rv_pipe_pkg::a_sel_e    a_sel,
    input  wire rv_pipe_pkg::b_sel_e    b_sel,
    input  wire rv_isa_pkg::branch_e    branch,
    input  wire rv_pipe_pkg::fwd_sel_e  fwd_a,
    input  wire rv_pipe_pkg::fwd_sel_e  fwd_b,
    input  wire [`XLEN-1:0]         mem_result,
    input  wire [`XLEN-1:0]         wb_result,
    output logic [`XLEN-1:0]        alu_result,
    output logic [`XLEN-1:0]        store_data,
    output logic [`XLEN-1:0]        target,
    output logic                    taken
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [`XLEN-1:0]   src_a;
    logic [`XLEN-1:0]   src_b;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic               signed_lt;

    function automatic logic [`XLEN-1:0] pick(fwd_sel_e sel, logic [`XLEN-1:0] reg_val,
                                              logic [`XLEN-1:0] mem_val,
                                              logic [`XLEN-1:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = pick(fwd_a, rs1_data, mem_result, wb_result);
    assign src_b = pick(fwd_b, rs2_data, mem_result, wb_result);

    assign op_a = (a_sel == A_PC) ? pc : src_a;
    assign op_b = (b_sel == B_IMM) ? imm : (b_sel == B_FOUR) ? `XLEN'(4) : src_b;

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_result = op_a << op_b[4:0];
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    assign store_data = src_b;
    assign target     = pc + imm;   // Same target for branches and JAL.
    assign signed_lt  = $signed(src_a) < $signed(src_b);

    always_comb begin
        case (branch)
            BR_EQ:   taken = (src_a == src_b);
            BR_NE:   taken = (src_a != src_b);
            BR_LT:   taken = signed_lt;
            BR_GE:   taken = !signed_lt;
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/rv_hazard_unit.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module rv_hazard_unit (
    input  wire [`REG_ADDR_W-1:0]       id_rs1,
    input  wire [`REG_ADDR_W-1:0]       id_rs2,
    input  wire [`REG_ADDR_W-1:0]       ex_rs1,
    input  wire [`REG_ADDR_W-1:0]       ex_rs2,
    input  wire [`REG_ADDR_W-1:0]       ex_rd,
    input  wire                         ex_mem_to_reg,
    input  wire [`REG_ADDR_W-1:0]       mem_rd,
    input  wire                         mem_reg_we,
    input  wire [`REG_ADDR_W-1:0]       wb_rd,
    input  wire                         wb_reg_we,
    input  wire                         taken,
    output rv_pipe_pkg::fwd_sel_e       fwd_a,
    output rv_pipe_pkg::fwd_sel_e       fwd_b,
    output rv_pipe_pkg::stage_ctrl_e    pc_ctrl,
    output rv_pipe_pkg::stage_ctrl_e    if_id_ctrl,
    output rv_pipe_pkg::stage_ctrl_e    id_ex_ctrl
);
    import rv_pipe_pkg::*;

    logic load_use;

    // The memory stage holds the younger result, so it is checked first.
    function automatic fwd_sel_e source(logic [`REG_ADDR_W-1:0] rs,
                                        logic [`REG_ADDR_W-1:0] m_rd, logic m_we,
                                        logic [`REG_ADDR_W-1:0] w_rd, logic w_we);
        if (m_we && m_rd != '0 && m_rd == rs) return FWD_MEM;
        if (w_we && w_rd != '0 && w_rd == rs) return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd_a = source(ex_rs1, mem_rd, mem_reg_we, wb_rd, wb_reg_we);
    assign fwd_b = source(ex_rs2, mem_rd, mem_reg_we, wb_rd, wb_reg_we);

    assign load_use = ex_mem_to_reg && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

    always_comb begin
        pc_ctrl    = STAGE_RUN;
        if_id_ctrl = STAGE_RUN;
        id_ex_ctrl = STAGE_RUN;
        if (taken) begin
            if_id_ctrl = STAGE_FLUSH;   // Kill the two younger instructions.
            id_ex_ctrl = STAGE_FLUSH;
        end else if (load_use) begin
            pc_ctrl    = STAGE_PAUSE;
            if_id_ctrl = STAGE_PAUSE;
            id_ex_ctrl = STAGE_FLUSH;   // Bubble while the load reaches memory.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module rv_pipeline (
    input  wire                 clk,
    input  wire                 arst_n,
    output logic [`XLEN-1:0]    imem_addr,
    input  wire [`XLEN-1:0]     imem_data,
    output logic [`XLEN-1:0]    dmem_addr,
    output logic [`XLEN-1:0]    dmem_wdata,
    output logic                dmem_we,
    input  wire [`XLEN-1:0]     dmem_rdata
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       id_pc, id_instr, id_imm, id_rs1_data, id_rs2_data;
    logic [`REG_ADDR_W-1:0] id_rd, id_rs1, id_rs2;
    alu_op_e                id_alu_op, ex_alu_op;
    a_sel_e                 id_a_sel, ex_a_sel;
    b_sel_e                 id_b_sel, ex_b_sel;
    branch_e                id_branch, ex_branch;
    logic                   id_reg_we, id_mem_to_reg, id_mem_we;
    // A prefix names the stage that the value currently sits in.
    logic [`XLEN-1:0]       ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
    logic [`REG_ADDR_W-1:0] ex_rd, ex_rs1, ex_rs2;
    logic                   ex_reg_we, ex_mem_to_reg, ex_mem_we, ex_taken;
    logic [`XLEN-1:0]       ex_alu_result, ex_store_data, ex_target;
    logic [`XLEN-1:0]       mem_alu_result, mem_store_data;
    logic [`REG_ADDR_W-1:0] mem_rd, wb_rd;
    logic                   mem_reg_we, mem_mem_to_reg, mem_mem_we;
    logic [`XLEN-1:0]       wb_alu_result, wb_rdata, wb_result;
    logic                   wb_reg_we, wb_mem_to_reg;
    fwd_sel_e               fwd_a, fwd_b;
    stage_ctrl_e            pc_ctrl, if_id_ctrl, id_ex_ctrl;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (pc_ctrl != STAGE_PAUSE) begin
            pc <= ex_taken ? ex_target : pc + `XLEN'(4);
        end
    end

    assign imem_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_instr <= '0;             // Opcode zero decodes as a no-op.
        end else if (if_id_ctrl == STAGE_FLUSH) begin
            id_instr <= '0;
        end else if (if_id_ctrl == STAGE_RUN) begin
            id_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_ctrl == STAGE_RUN) id_pc <= pc;
    end

    rv_decoder u_decoder (
        .instr(id_instr), .rd(id_rd), .rs1_addr(id_rs1), .rs2_addr(id_rs2), .imm(id_imm),
        .alu_op(id_alu_op), .a_sel(id_a_sel), .b_sel(id_b_sel), .branch(id_branch),
        .reg_we(id_reg_we), .mem_to_reg(id_mem_to_reg), .mem_we(id_mem_we)
    );

    rv_regfile u_regfile (
        .clk(clk), .arst_n(arst_n), .rs1_addr(id_rs1), .rs2_addr(id_rs2),
        .rs1_data(id_rs1_data), .rs2_data(id_rs2_data),
        .wr_addr(wb_rd), .wr_data(wb_result), .wr_en(wb_reg_we)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_reg_we     <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_mem_we     <= 1'b0;
            ex_branch     <= BR_NONE;
        end else if (id_ex_ctrl == STAGE_FLUSH) begin
            ex_reg_we     <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_mem_we     <= 1'b0;
            ex_branch     <= BR_NONE;
        end else if (id_ex_ctrl == STAGE_RUN) begin
            ex_reg_we     <= id_reg_we;
            ex_mem_to_reg <= id_mem_to_reg;
            ex_mem_we     <= id_mem_we;
            ex_branch     <= id_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (id_ex_ctrl == STAGE_RUN) begin
            ex_pc       <= id_pc;
            ex_imm      <= id_imm;
            ex_rs1_data <= id_rs1_data;
            ex_rs2_data <= id_rs2_data;
            ex_rs1      <= id_rs1;
            ex_rs2      <= id_rs2;
            ex_rd       <= id_rd;
            ex_alu_op   <= id_alu_op;
            ex_a_sel    <= id_a_sel;
            ex_b_sel    <= id_b_sel;
        end
    end

    rv_execute u_execute (
        .pc(ex_pc), .imm(ex_imm), .rs1_data(ex_rs1_data), .rs2_data(ex_rs2_data),
        .alu_op(ex_alu_op), .a_sel(ex_a_sel), .b_sel(ex_b_sel), .branch(ex_branch),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_result(mem_alu_result), .wb_result(wb_result),
        .alu_result(ex_alu_result), .store_data(ex_store_data), .target(ex_target),
        .taken(ex_taken)
    );

    rv_hazard_unit u_hazard_unit (
        .id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .ex_mem_to_reg(ex_mem_to_reg), .mem_rd(mem_rd), .mem_reg_we(mem_reg_we),
        .wb_rd(wb_rd), .wb_reg_we(wb_reg_we), .taken(ex_taken), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .pc_ctrl(pc_ctrl), .if_id_ctrl(if_id_ctrl), .id_ex_ctrl(id_ex_ctrl)
    );

    // Memory and writeback registers never stall.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_reg_we <= 1'b0;
            mem_mem_we <= 1'b0;
            wb_reg_we  <= 1'b0;
        end else begin
            mem_reg_we <= ex_reg_we;
            mem_mem_we <= ex_mem_we;
            wb_reg_we  <= mem_reg_we;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result <= ex_alu_result;
        mem_store_data <= ex_store_data;
        mem_rd         <= ex_rd;
        mem_mem_to_reg <= ex_mem_to_reg;
        wb_alu_result  <= mem_alu_result;
        wb_rdata       <= dmem_rdata;
        wb_rd          <= mem_rd;
        wb_mem_to_reg  <= mem_mem_to_reg;
    end

    assign dmem_addr  = mem_alu_result;
    assign dmem_wdata = mem_store_data;
    assign dmem_we    = mem_mem_we;

    assign wb_result = wb_mem_to_reg ? wb_rdata : wb_alu_result;

endmodule

`default_nettype wire

// ==== test/tb_rv_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module tb_rv_pipeline;
    import rv_isa_pkg::*;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic [`XLEN-1:0]       imem_addr;
    logic [`XLEN-1:0]       imem_data;
    logic [`XLEN-1:0]       dmem_addr;
    logic [`XLEN-1:0]       dmem_wdata;
    logic                   dmem_we;
    logic [`XLEN-1:0]       dmem_rdata;
    logic [`XLEN-1:0]       imem [0:255];
    logic [`XLEN-1:0]       dmem [0:255];
    logic [`XLEN-1:0]       exp_addr [$];
    logic [`XLEN-1:0]       exp_data [$];
    int                     n_instr;
    int                     got;
    int                     exp_total;
    int                     failures = 0;
    int                     seed = 32'hd62128bb;
    time                    deadline = 64'd1_000_000_000;

    rv_pipeline dut0 (
        .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    always #20 clk = ~clk;

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
    end

    function automatic logic [31:0] r_op(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                         logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_op(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                         logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sw_op(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] br_op(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] lui_op(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] jal_op(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Every bit of the word index takes part in the pattern.
    function automatic logic [31:0] fill_word(int i);
        logic [31:0] a;
        a = i;
        return (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    // Instruction-level model, runs until the closing self-jump.
    function automatic void run_reference();
        logic [31:0] r [32];
        logic [31:0] m [256];
        logic [31:0] pc, ins, a, b, nxt, addr, imm_i, imm_s, imm_b, imm_j;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          steps;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) m[i] = fill_word(i);
        pc = `RESET_PC;
        steps = 0;
        while (steps < 100000) begin
            ins = imem[pc[9:2]];
            if (ins == jal_op(5'd0, 21'd0)) break;
            rd = ins[11:7];
            f3 = ins[14:12];
            f7 = ins[31:25];
            a = r[ins[19:15]];
            b = r[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            nxt = pc + 4;
            case (ins[6:0])
                OPC_OP: case ({f7, f3})
                    {7'h00, 3'd0}: r[rd] = a + b;
                    {7'h20, 3'd0}: r[rd] = a - b;
                    {7'h00, 3'd1}: r[rd] = a << b[4:0];
                    {7'h00, 3'd2}: r[rd] = ($signed(a) < $signed(b)) ? 1 : 0;
                    {7'h00, 3'd4}: r[rd] = a ^ b;
                    {7'h00, 3'd5}: r[rd] = a >> b[4:0];
                    {7'h20, 3'd5}: r[rd] = $signed(a) >>> b[4:0];
                    {7'h00, 3'd6}: r[rd] = a | b;
                    {7'h00, 3'd7}: r[rd] = a & b;
                    default: ;
                endcase
                OPC_OP_IMM: case (f3)
                    3'd0: r[rd] = a + imm_i;
                    3'd2: r[rd] = ($signed(a) < $signed(imm_i)) ? 1 : 0;
                    3'd4: r[rd] = a ^ imm_i;
                    3'd6: r[rd] = a | imm_i;
                    3'd7: r[rd] = a & imm_i;
                    default: ;
                endcase
                OPC_LUI: r[rd] = {ins[31:12], 12'b0};
                OPC_LOAD: begin
                    addr = a + imm_i;
                    if (f3 == 3'd2) r[rd] = m[addr[9:2]];
                end
                OPC_STORE: begin
                    addr = a + imm_s;
                    if (f3 == 3'd2) begin
                        m[addr[9:2]] = b;
                        exp_addr.push_back(addr);
                        exp_data.push_back(b);
                    end
                end
                OPC_BRANCH: begin
                    if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b) ||
                        (f3 == 3'd4 && $signed(a) < $signed(b)) ||
                        (f3 == 3'd5 && $signed(a) >= $signed(b))) nxt = pc + imm_b;
                end
                OPC_JAL: begin
                    r[rd] = pc + 4;
                    nxt = pc + imm_j;
                end
                default: ;
            endcase
            r[0] = '0;
            pc = nxt;
            steps++;
        end
        exp_total = exp_addr.size();
    endfunction

    task automatic stop_with_error(string why);
        failures++;
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(logic [31:0] actual, logic [31:0] expected, string what);
        if (actual !== expected) begin
            failures++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Outputs settle after the rising edge, so the store port is read at the falling one.
    always @(negedge clk) begin
        if (arst_n && dmem_we) begin
            if (exp_addr.size() == 0) begin
                stop_with_error("the DUT wrote to data memory where no store was expected");
            end else begin
                check_value(dmem_addr, exp_addr.pop_front(), "store address");
                check_value(dmem_wdata, exp_data.pop_front(), "store data");
                got++;
            end
        end
    end

    always @(negedge clk) begin
        if ($time > deadline) stop_with_error("timeout, the program did not finish its stores");
    end

    task automatic begin_program();
        arst_n = 1'b0;
        n_instr = 0;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i);
        end
    endtask

    task automatic emit(logic [31:0] word);
        imem[n_instr] = word;
        n_instr++;
    endtask

    task automatic run_program();
        emit(jal_op(5'd0, 21'd0));
        run_reference();
        got = 0;
        deadline = $time + (n_instr * 20 + 8) * 40;
        repeat (8) @(posedge clk);
        #2 arst_n = 1'b1;
        check_value(imem_addr, `RESET_PC, "fetch address after reset");
        check_value(dmem_we, 1'b0, "store strobe after reset");
        wait (imem_addr == 32'((n_instr - 1) * 4));
        // Older instructions reach memory within a few cycles of the final fetch.
        repeat (8) @(posedge clk);
        #2;
        check_value(got, exp_total, "number of stores");
    endtask

    initial begin
        int          addr;
        logic [31:0] rnd;
        logic [2:0]  f3s [4];
        logic [4:0]  t_a [8];
        logic [4:0]  t_b [8];
        logic [6:0]  r_f7 [9];
        logic [2:0]  r_f3 [9];
        logic [2:0]  i_f3 [5];
        f3s  = '{3'd0, 3'd1, 3'd4, 3'd5};
        // Pairs that take each branch, then pairs that fall through.
        t_a  = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd1, 5'd1, 5'd2};
        t_b  = '{5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1};
        r_f7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        r_f3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        i_f3 = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7};
        arst_n = 1'b0;

        // Dependent ALU chain.
        begin_program();
        emit(lui_op(5'd1, 20'h12345));
        emit(i_op(OPC_OP_IMM, 3'd0, 5'd1, 5'd1, 12'h678));
        emit(r_op(7'h00, 3'd0, 5'd2, 5'd1, 5'd1));
        emit(r_op(7'h20, 3'd0, 5'd3, 5'd2, 5'd1));
        emit(i_op(OPC_OP_IMM, 3'd0, 5'd4, 5'd0, 12'hffb));
        emit(r_op(7'h00, 3'd2, 5'd5, 5'd4, 5'd1));
        emit(r_op(7'h00, 3'd1, 5'd6, 5'd1, 5'd5));
        emit(r_op(7'h00, 3'd5, 5'd7, 5'd4, 5'd5));
        emit(r_op(7'h20, 3'd5, 5'd8, 5'd4, 5'd5));
        emit(r_op(7'h00, 3'd4, 5'd9, 5'd7, 5'd8));
        emit(r_op(7'h00, 3'd6, 5'd10, 5'd9, 5'd3));
        emit(r_op(7'h00, 3'd7, 5'd11, 5'd10, 5'd2));
        emit(i_op(OPC_OP_IMM, 3'd2, 5'd12, 5'd4, 12'hffd));
        emit(i_op(OPC_OP_IMM, 3'd4, 5'd13, 5'd11, 12'h5a5));
        emit(i_op(OPC_OP_IMM, 3'd6, 5'd14, 5'd13, 12'h0f0));
        emit(i_op(OPC_OP_IMM, 3'd7, 5'd15, 5'd14, 12'h7ff));
        for (int i = 1; i <= 15; i++) emit(sw_op(5'(i), 5'd0, 12'(i * 4)));
        run_program();

        // Loads used right away.
        begin_program();
        emit(i_op(OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'h040));
        emit(i_op(OPC_LOAD, 3'd2, 5'd2, 5'd1, 12'h000));
        emit(i_op(OPC_OP_IMM, 3'd0, 5'd3, 5'd2, 12'h001));
        emit(sw_op(5'd3, 5'd0, 12'h300));
        emit(i_op(OPC_LOAD, 3'd2, 5'd4, 5'd1, 12'h004));
        emit(r_op(7'h00, 3'd0, 5'd5, 5'd4, 5'd4));
        emit(sw_op(5'd5, 5'd0, 12'h304));
        emit(i_op(OPC_LOAD, 3'd2, 5'd6, 5'd1, 12'h008));
        emit(sw_op(5'd6, 5'd1, 12'h010));
        run_program();

        // Each branch kind taken, then not taken, with stores in its shadow.
        begin_program();
        addr = 12'h100;
        emit(i_op(OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'h005));
        emit(i_op(OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'hffd));
        for (int k = 0; k < 8; k++) begin
            emit(i_op(OPC_OP_IMM, 3'd0, 5'd3, 5'd3, 12'h001));
            emit(br_op(f3s[k % 4], t_a[k], t_b[k], 13'd12));
            emit(sw_op(5'd3, 5'd0, 12'(addr)));
            emit(sw_op(5'd3, 5'd0, 12'(addr + 4)));
            emit(sw_op(5'd3, 5'd0, 12'(addr + 8)));
            addr += 12;
        end
        run_program();

        // JAL skips two stores and links.
        begin_program();
        emit(i_op(OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'h007));
        emit(jal_op(5'd5, 21'd12));
        emit(sw_op(5'd1, 5'd0, 12'h200));
        emit(sw_op(5'd1, 5'd0, 12'h204));
        emit(sw_op(5'd5, 5'd0, 12'h208));
        run_program();

        // Random ALU program, then dump the register file.
        begin_program();
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            if (rnd[31:28] < 4'd9) begin
                emit(r_op(r_f7[rnd[31:28]], r_f3[rnd[31:28]], rnd[4:0], rnd[9:5], rnd[14:10]));
            end else begin
                emit(i_op(OPC_OP_IMM, i_f3[rnd[30:28] % 5], rnd[4:0], rnd[9:5], rnd[26:15]));
            end
        end
        for (int i = 1; i < 32; i++) emit(sw_op(5'(i), 5'd0, 12'(12'h100 + i * 4)));
        run_program();

        if (failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_hazard_unit.sv
hdl/rv_pipeline.sv
test/tb_rv_pipeline.sv
